/* Makefile */
# Verilator build and run of the load/store unit testbench

SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module lsu_tb -Mdir obj_dir -o lsu_tb -f sources.f
	./obj_dir/lsu_tb | tee $(SIM_LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(SIM_LOG) || (echo "Simulation failed, see $(SIM_LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(SIM_LOG)

/* dv/lsu_tb.sv */
// Testbench for the load/store unit
// Random loads and stores against a behavioral memory and a reference model
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb;

    localparam int NUM_OPS      = 200;
    localparam int RESET_CYCLES = 8;
    localparam int OP_TIMEOUT   = 20;

    logic        clk;
    logic        rst_n;
    logic        opcode_valid_i;
    logic [31:0] opcode_i;
    logic [31:0] ra_operand_i;
    logic [31:0] rb_operand_i;
    logic        stall_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_data_wr_o;
    logic        mem_rd_o;
    logic [3:0]  mem_wr_o;
    logic        mem_accept_i;
    logic        mem_ack_i;
    logic        mem_error_i;
    logic [31:0] mem_data_rd_i;
    logic        writeback_valid_o;
    logic [31:0] writeback_value_o;
    logic [5:0]  writeback_exception_o;

    // Expected request of the current op
    // The memory model checks every request against it
    logic        exp_rd;
    logic [3:0]  exp_strb;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    string       cur_name;
    int          err_count  = 0;
    int          fail_count = 0;
    int          req_count  = 0;
    logic [31:0] mirror [256];

    string      op_name   [8] = '{"LB", "LH", "LW", "LBU", "LHU", "SB", "SH", "SW"};
    int         op_size   [8] = '{1, 2, 4, 1, 2, 1, 2, 4};
    logic [2:0] op_funct3 [8] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd0, 3'd1, 3'd2};

    lsu_top UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Distinct initial word for every memory address
    function automatic logic [31:0] fill_word(input int idx);
        fill_word = (32'h9e3779b1 * (idx + 1)) ^ {4{8'(idx)}};
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] off,
                                                input int size, input logic sgn);
        logic [31:0] lane;
        lane = word >> (8 * off);
        if (size == 1)
            return {{24{sgn & lane[7]}}, lane[7:0]};
        else if (size == 2)
            return {{16{sgn & lane[15]}}, lane[15:0]};
        return lane;
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("** Error %s %s: expected 0x%08h, actual 0x%08h", cur_name, what, exp, act);
        err_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error in %s: %s", cur_name, msg);
        err_count++;
    endtask

    // --------------------
    // One op from start to writeback
    // --------------------
    task automatic run_op(input int num, input int kind, input logic [31:0] ea,
                          input logic [31:0] wd, output logic wrote);
        logic [6:0]  r7;
        logic [31:0] imm;
        logic [31:0] exp_val;
        logic [5:0]  exp_exc;
        logic        is_load;
        logic        misal;
        logic        fault;
        int          err_before;
        int          req_before;
        int          cyc;
        is_load  = (kind < 5);
        misal    = (ea[1:0] & 2'(op_size[kind] - 1)) != 2'b00;
        fault    = !misal && (ea[9:2] >= 8'd240);
        r7       = 7'($urandom);
        imm      = {{25{r7[6]}}, r7};
        cur_name = $sformatf("%0d %s @0x%03h", num, op_name[kind], ea);
        exp_addr = {ea[31:2], 2'b00};
        exp_rd   = is_load && !misal;
        exp_data = wd << (8 * ea[1:0]);
        exp_strb = 4'h0;
        if (!is_load && !misal)
            exp_strb = (op_size[kind] == 4) ? 4'hf :
                       (op_size[kind] == 2) ? (4'h3 << ea[1:0]) : (4'h1 << ea[1:0]);
        // Misalignment wins over a bus error
        if (misal)
        begin
            exp_val = ea;
            exp_exc = is_load ? `LSU_EXC_MISALIGNED_LOAD : `LSU_EXC_MISALIGNED_STORE;
        end
        else if (fault)
        begin
            exp_val = ea;
            exp_exc = is_load ? `LSU_EXC_FAULT_LOAD : `LSU_EXC_FAULT_STORE;
        end
        else
        begin
            exp_val = extend_load(mirror[ea[9:2]], ea[1:0], op_size[kind], kind < 2);
            exp_exc = 6'd0;
        end
        wrote = !is_load && !misal && !fault;
        if (wrote)
            for (int b = 0; b < 4; b++)
                if (exp_strb[b])
                    mirror[ea[9:2]][8*b +: 8] = exp_data[8*b +: 8];

        err_before = err_count;
        req_before = req_count;
        @(posedge clk);
        opcode_valid_i <= 1'b1;
        opcode_i       <= is_load ?
            {imm[11:0], 5'($urandom), op_funct3[kind], 5'($urandom), 7'h03} :
            {imm[11:5], 5'($urandom), 5'($urandom), op_funct3[kind], imm[4:0], 7'h23};
        ra_operand_i   <= ea - imm;
        rb_operand_i   <= wd;
        cyc = 0;
        do
        begin
            @(posedge clk);
            cyc++;
        end while (stall_o && cyc < OP_TIMEOUT);
        opcode_valid_i <= 1'b0;

        cyc = 0;
        do
        begin
            @(posedge clk);
            cyc++;
        end while (!writeback_valid_o && cyc < OP_TIMEOUT);
        if (!writeback_valid_o)
            note_failure("no writeback within the timeout");
        else
        begin
            if (writeback_exception_o !== exp_exc)
                report_value("exception", 32'(exp_exc), 32'(writeback_exception_o));
            if ((is_load || misal || fault) && writeback_value_o !== exp_val)
                report_value("value", exp_val, writeback_value_o);
            if (misal && cyc != 2)
                note_failure($sformatf("misaligned answer after %0d cycles, not 2", cyc));
        end
        if (misal && req_count != req_before)
            note_failure("misaligned access reached the memory");
        if (!misal && req_count != req_before + 1)
            note_failure("expected exactly one memory request");

        if (err_count == err_before)
            $display("%s: ok", cur_name);
        else
        begin
            $display("%s: FAIL", cur_name);
            fail_count++;
        end
    endtask

    // --------------------
    // Behavioral memory
    // --------------------
    initial
    begin : memory_model
        logic [31:0] mem [256];
        logic [31:0] req_addr;
        logic [31:0] req_data;
        logic [31:0] mask;
        logic        req_rd;
        logic [3:0]  req_wr;
        logic        req_err;
        int          delay;
        mem_accept_i  = 1'b0;
        mem_ack_i     = 1'b0;
        mem_error_i   = 1'b0;
        mem_data_rd_i = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = fill_word(i);
        forever
        begin
            @(posedge clk);
            if (rst_n && (mem_rd_o || mem_wr_o != 4'h0))
            begin
                req_count++;
                req_addr = mem_addr_o;
                req_data = mem_data_wr_o;
                req_rd   = mem_rd_o;
                req_wr   = mem_wr_o;
                mask     = {{8{req_wr[3]}}, {8{req_wr[2]}}, {8{req_wr[1]}}, {8{req_wr[0]}}};
                if (req_addr !== exp_addr)
                    report_value("mem_addr_o", exp_addr, req_addr);
                if (req_rd !== exp_rd)
                    report_value("mem_rd_o", 32'(exp_rd), 32'(req_rd));
                if (req_wr !== exp_strb)
                    report_value("mem_wr_o", 32'(exp_strb), 32'(req_wr));
                if ((req_data & mask) !== (exp_data & mask))
                    report_value("store lanes", exp_data & mask, req_data & mask);
                if (!stall_o)
                    note_failure("stall_o low while a request waits for accept");
                // Back-pressure before the accept
                delay = $urandom % 4;
                repeat (delay)
                begin
                    @(posedge clk);
                    if (!stall_o)
                        note_failure("stall_o low while a request waits for accept");
                    if (mem_addr_o !== req_addr || mem_data_wr_o !== req_data ||
                        mem_rd_o !== req_rd || mem_wr_o !== req_wr)
                        note_failure("request changed before it was accepted");
                end
                mem_accept_i <= 1'b1;
                @(posedge clk);
                mem_accept_i <= 1'b0;
                // Top 16 words answer with a bus error
                req_err = (req_addr[9:2] >= 8'd240);
                if (!req_err)
                    for (int b = 0; b < 4; b++)
                        if (req_wr[b])
                            mem[req_addr[9:2]][8*b +: 8] = req_data[8*b +: 8];
                repeat ($urandom % 4)
                    @(posedge clk);
                mem_ack_i     <= 1'b1;
                mem_error_i   <= req_err;
                mem_data_rd_i <= mem[req_addr[9:2]];
                @(posedge clk);
                mem_ack_i     <= 1'b0;
                mem_error_i   <= 1'b0;
                mem_data_rd_i <= $urandom;
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin : stimulus
        int          n;
        int          kind;
        logic [31:0] ea;
        logic        wrote;
        void'($urandom(32'h77a0e3fd));
        rst_n          = 1'b0;
        opcode_valid_i = 1'b0;
        opcode_i       = '0;
        ra_operand_i   = '0;
        rb_operand_i   = '0;
        for (int i = 0; i < 256; i++)
            mirror[i] = fill_word(i);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        n = 0;
        while (n < NUM_OPS)
        begin
            kind = $urandom % 8;
            ea   = $urandom % 1024;
            // Three in four addresses are naturally aligned
            if ($urandom % 4 != 0)
                ea = ea & ~32'(op_size[kind] - 1);
            run_op(n, kind, ea, $urandom, wrote);
            n++;
            // Read back the word just stored
            if (wrote && $urandom % 2 == 0 && n < NUM_OPS)
            begin
                run_op(n, 2, ea & 32'hffff_fffc, $urandom, wrote);
                n++;
            end
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d tests, %0d failed, %0d errors", n, fail_count, err_count);
        if (err_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin : watchdog
        repeat (RESET_CYCLES + NUM_OPS * 20) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles",
                 RESET_CYCLES + NUM_OPS * 20);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_tag_if.sv
src/lsu_issue.sv
src/lsu_tag_fifo.sv
src/lsu_response.sv
src/lsu_top.sv
dv/lsu_tb.sv

/* src/lsu_defines.svh */
// LSU data and strobe widths, exception code width
// Response tag FIFO depth and pointer widths
// Opcode match and mask patterns for the supported loads and stores
// Exception cause codes
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Datapath widths
`define LSU_XLEN            32
`define LSU_STRB_W          4
`define LSU_EXC_W           6

// Response tag FIFO, counter holds 0 to depth
`define LSU_FIFO_DEPTH      2
`define LSU_FIFO_PTR_W      1
`define LSU_FIFO_CNT_W      2

// Loads
`define LSU_INST_LB         32'h00000003
`define LSU_INST_LB_MASK    32'h0000707f
`define LSU_INST_LH         32'h00001003
`define LSU_INST_LH_MASK    32'h0000707f
`define LSU_INST_LW         32'h00002003
`define LSU_INST_LW_MASK    32'h0000707f
`define LSU_INST_LBU        32'h00004003
`define LSU_INST_LBU_MASK   32'h0000707f
`define LSU_INST_LHU        32'h00005003
`define LSU_INST_LHU_MASK   32'h0000707f

// Stores
`define LSU_INST_SB         32'h00000023
`define LSU_INST_SB_MASK    32'h0000707f
`define LSU_INST_SH         32'h00001023
`define LSU_INST_SH_MASK    32'h0000707f
`define LSU_INST_SW         32'h00002023
`define LSU_INST_SW_MASK    32'h0000707f

// Exception causes, zero means none
`define LSU_EXC_MISALIGNED_LOAD     6'd4
`define LSU_EXC_FAULT_LOAD          6'd5
`define LSU_EXC_MISALIGNED_STORE    6'd6
`define LSU_EXC_FAULT_STORE         6'd7

`endif

/* src/lsu_issue.sv */
// LSU request issuer
// Opcode decode, effective address and store lane placement
// E1 request register, outstanding response tracking and fault squash
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_issue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    opcode_valid_i,
    input  lsu_pkg::opcode_u        opcode_i,
    input  logic [`LSU_XLEN-1:0]    ra_operand_i,
    input  logic [`LSU_XLEN-1:0]    rb_operand_i,
    input  logic                    mem_accept_i,
    input  logic                    mem_ack_i,
    output logic [`LSU_XLEN-1:0]    mem_addr_o,
    output logic [`LSU_XLEN-1:0]    mem_data_wr_o,
    output logic                    mem_rd_o,
    output logic [`LSU_STRB_W-1:0]  mem_wr_o,
    output logic                    stall_o,
    lsu_tag_if.issue                tag
);

    // --------------------
    // Decode
    // --------------------
    logic lb_w;
    logic lh_w;
    logic lw_w;
    logic lbu_w;
    logic lhu_w;
    logic sb_w;
    logic sh_w;
    logic sw_w;
    logic load_w;
    logic byte_w;
    logic half_w;
    logic word_w;
    logic signed_w;

    assign lb_w  = (opcode_i & `LSU_INST_LB_MASK) == `LSU_INST_LB;
    assign lh_w  = (opcode_i & `LSU_INST_LH_MASK) == `LSU_INST_LH;
    assign lw_w  = (opcode_i & `LSU_INST_LW_MASK) == `LSU_INST_LW;
    assign lbu_w = (opcode_i & `LSU_INST_LBU_MASK) == `LSU_INST_LBU;
    assign lhu_w = (opcode_i & `LSU_INST_LHU_MASK) == `LSU_INST_LHU;
    assign sb_w  = (opcode_i & `LSU_INST_SB_MASK) == `LSU_INST_SB;
    assign sh_w  = (opcode_i & `LSU_INST_SH_MASK) == `LSU_INST_SH;
    assign sw_w  = (opcode_i & `LSU_INST_SW_MASK) == `LSU_INST_SW;

    assign load_w   = lb_w | lh_w | lw_w | lbu_w | lhu_w;
    assign byte_w   = lb_w | lbu_w | sb_w;
    assign half_w   = lh_w | lhu_w | sh_w;
    assign word_w   = lw_w | sw_w;
    assign signed_w = lb_w | lh_w;

    // --------------------
    // Address and lanes
    // --------------------
    logic [`LSU_XLEN-1:0]   imm_w;
    logic [`LSU_XLEN-1:0]   addr_w;
    logic                   misalign_w;
    logic [`LSU_XLEN-1:0]   wr_data_w;
    logic [`LSU_STRB_W-1:0] wr_strb_w;

    // I-immediate for loads, split S-immediate for stores
    assign imm_w = load_w ?
        {{(`LSU_XLEN-12){opcode_i.i.imm[11]}}, opcode_i.i.imm} :
        {{(`LSU_XLEN-12){opcode_i.s.imm_hi[6]}}, opcode_i.s.imm_hi, opcode_i.s.imm_lo};

    assign addr_w     = ra_operand_i + imm_w;
    assign misalign_w = (word_w & (addr_w[1:0] != 2'b00)) | (half_w & addr_w[0]);

    // Narrow store data is replicated so every candidate lane carries it
    always_comb
    begin
        wr_data_w = rb_operand_i;
        wr_strb_w = '0;
        if (sw_w)
            wr_strb_w = 4'b1111;
        else if (sh_w)
        begin
            wr_data_w = {2{rb_operand_i[15:0]}};
            wr_strb_w = addr_w[1] ? 4'b1100 : 4'b0011;
        end
        else if (sb_w)
        begin
            wr_data_w = {4{rb_operand_i[7:0]}};
            wr_strb_w = 4'b0001 << addr_w[1:0];
        end
    end

    // --------------------
    // E1 and tracking
    // --------------------
    logic                   rd_q;
    logic [`LSU_STRB_W-1:0] wr_q;
    logic                   misalign_q;
    logic                   misalign_ack_q;
    logic                   pending_q;
    logic [`LSU_XLEN-1:0]   addr_q;
    logic [`LSU_XLEN-1:0]   data_q;
    logic                   load_q;
    logic                   signed_q;
    logic                   half_q;
    logic                   byte_q;
    logic                   delay_w;
    logic                   req_vis_w;
    logic                   issue_w;
    logic                   misalign_push_w;

    // Hold the next op while the outstanding response is late or faulting
    assign delay_w   = pending_q & ~(mem_ack_i & ~tag.fault_seen);
    assign mem_rd_o  = rd_q & ~delay_w;
    assign mem_wr_o  = wr_q & ~{`LSU_STRB_W{delay_w}};
    assign req_vis_w = mem_rd_o | (|mem_wr_o);
    assign issue_w   = req_vis_w & mem_accept_i;

    // One local answer per misaligned op
    assign misalign_push_w = misalign_q & ~delay_w & ~misalign_ack_q;

    assign stall_o = (req_vis_w & ~mem_accept_i) | delay_w | misalign_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_q       <= 1'b0;
            wr_q       <= '0;
            misalign_q <= 1'b0;
        end
        else if (tag.fault_seen)
        begin
            // Squash whatever sits behind the fault
            rd_q       <= 1'b0;
            wr_q       <= '0;
            misalign_q <= 1'b0;
        end
        else if (!stall_o)
        begin
            rd_q       <= opcode_valid_i & load_w & ~misalign_w;
            wr_q       <= (opcode_valid_i & ~misalign_w) ? wr_strb_w : '0;
            misalign_q <= opcode_valid_i & misalign_w;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_o)
        begin
            addr_q   <= addr_w;
            data_q   <= wr_data_w;
            load_q   <= load_w;
            signed_q <= signed_w;
            half_q   <= half_w;
            byte_q   <= byte_w;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending_q      <= 1'b0;
            misalign_ack_q <= 1'b0;
        end
        else
        begin
            misalign_ack_q <= misalign_push_w;
            if (issue_w)
                pending_q <= 1'b1;
            else if (mem_ack_i)
                pending_q <= 1'b0;
        end
    end

    assign mem_addr_o    = {addr_q[`LSU_XLEN-1:2], 2'b00};
    assign mem_data_wr_o = data_q;

    // Tag goes out with every accepted request or local answer
    assign tag.push         = issue_w | misalign_push_w;
    assign tag.tag_addr     = addr_q;
    assign tag.tag_load     = load_q;
    assign tag.tag_signed   = signed_q;
    assign tag.tag_half     = half_q;
    assign tag.tag_byte     = byte_q;
    assign tag.misalign_ack = misalign_ack_q;

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rd_o && (|mem_wr_o)));

    // A refused request is presented again unchanged
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req_vis_w && !mem_accept_i) |=>
        ($stable(mem_rd_o) && $stable(mem_wr_o) && $stable(mem_addr_o) &&
         $stable(mem_data_wr_o)));

endmodule

/* src/lsu_pkg.sv */
// LSU shared types
// Instruction word with I-type and S-type field views

package lsu_pkg;

    // Loads see one 12-bit immediate, stores see it split around rs2
    typedef union packed {
        // I-type view
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        // S-type view
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s;
    } opcode_u;

endpackage

/* src/lsu_response.sv */
// LSU response formatter
// Load lane extraction and sign or zero extension
// Exception selection and squash request to the issuer
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_response (
    input  logic                    mem_ack_i,
    input  logic                    mem_error_i,
    input  logic [`LSU_XLEN-1:0]    mem_data_rd_i,
    output logic                    writeback_valid_o,
    output logic [`LSU_XLEN-1:0]    writeback_value_o,
    output logic [`LSU_EXC_W-1:0]   writeback_exception_o,
    lsu_tag_if.resp                 tag
);

    logic                   bus_fault_w;
    logic                   fault_w;
    logic [7:0]             byte_w;
    logic [15:0]            half_w;
    logic [`LSU_XLEN-1:0]   load_value_w;

    assign bus_fault_w = mem_ack_i & mem_error_i;
    assign fault_w     = bus_fault_w | tag.misalign_ack;

    // Every memory ack or local answer retires the head tag
    assign tag.pop        = mem_ack_i | tag.misalign_ack;
    assign tag.fault_seen = fault_w;

    // --------------------
    // Load data
    // --------------------
    always_comb
    begin
        case (tag.head_addr[1:0])
            2'd0:    byte_w = mem_data_rd_i[7:0];
            2'd1:    byte_w = mem_data_rd_i[15:8];
            2'd2:    byte_w = mem_data_rd_i[23:16];
            default: byte_w = mem_data_rd_i[31:24];
        endcase

        half_w = tag.head_addr[1] ? mem_data_rd_i[31:16] : mem_data_rd_i[15:0];

        if (tag.head_byte)
            load_value_w = {{(`LSU_XLEN-8){tag.head_signed & byte_w[7]}}, byte_w};
        else if (tag.head_half)
            load_value_w = {{(`LSU_XLEN-16){tag.head_signed & half_w[15]}}, half_w};
        else
            load_value_w = mem_data_rd_i;
    end

    // --------------------
    // Writeback
    // --------------------
    assign writeback_valid_o = mem_ack_i | tag.misalign_ack;

    // Faults report the effective address
    assign writeback_value_o = fault_w ? tag.head_addr :
                               (mem_ack_i && tag.head_load) ? load_value_w : '0;

    // Misalignment wins over a bus error
    always_comb
    begin
        if (tag.misalign_ack)
            writeback_exception_o = tag.head_load ? `LSU_EXC_MISALIGNED_LOAD :
                                                    `LSU_EXC_MISALIGNED_STORE;
        else if (bus_fault_w)
            writeback_exception_o = tag.head_load ? `LSU_EXC_FAULT_LOAD :
                                                    `LSU_EXC_FAULT_STORE;
        else
            writeback_exception_o = '0;
    end

    // A response without an issued request means the memory broke ordering
    always_comb
    begin
        if (mem_ack_i)
            assert (tag.head_valid)
            else $error("lsu_response: memory ack with no tag in the FIFO");
    end

endmodule

/* src/lsu_tag_fifo.sv */
// Two-entry response tag FIFO
// Circular buffer with read and write pointers and an occupancy count
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tag_fifo (
    input  logic    clk,
    input  logic    rst_n,
    lsu_tag_if.fifo tag
);

    logic [`LSU_XLEN+3:0]       entry_q [`LSU_FIFO_DEPTH];
    logic [`LSU_FIFO_PTR_W-1:0] wr_ptr_q;
    logic [`LSU_FIFO_PTR_W-1:0] rd_ptr_q;
    logic [`LSU_FIFO_CNT_W-1:0] count_q;
    logic                       full_w;

    assign full_w = (count_q == `LSU_FIFO_CNT_W'(`LSU_FIFO_DEPTH));

    // Tag storage holds the address then the load, signed, half and byte flags
    always_ff @(posedge clk)
    begin
        if (tag.push)
            entry_q[wr_ptr_q] <= {tag.tag_addr, tag.tag_load, tag.tag_signed,
                                  tag.tag_half, tag.tag_byte};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (tag.push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (tag.pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (tag.push && !tag.pop)
                count_q <= count_q + `LSU_FIFO_CNT_W'(1);
            else if (!tag.push && tag.pop)
                count_q <= count_q - `LSU_FIFO_CNT_W'(1);
        end
    end

    assign tag.head_valid = (count_q != '0);
    assign {tag.head_addr, tag.head_load, tag.head_signed, tag.head_half, tag.head_byte} =
        entry_q[rd_ptr_q];

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        tag.push |-> !full_w);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        tag.pop |-> tag.head_valid);

endmodule

/* src/lsu_tag_if.sv */
// Response tag bundle between issuer, tag FIFO and formatter
// Push side tag fields, FIFO head fields, misalign answer and squash
`timescale 1ns/1ps
`include "lsu_defines.svh"

interface lsu_tag_if;

    // Issuer to FIFO
    logic                   push;
    logic [`LSU_XLEN-1:0]   tag_addr;
    logic                   tag_load;
    logic                   tag_signed;
    logic                   tag_half;
    logic                   tag_byte;

    // FIFO head to formatter
    logic                   head_valid;
    logic [`LSU_XLEN-1:0]   head_addr;
    logic                   head_load;
    logic                   head_signed;
    logic                   head_half;
    logic                   head_byte;

    // Formatter pops, issuer answers misaligned ops locally
    logic                   pop;
    logic                   misalign_ack;
    logic                   fault_seen;

    modport issue (
        output push, tag_addr, tag_load, tag_signed, tag_half, tag_byte, misalign_ack,
        input  fault_seen
    );

    modport fifo (
        input  push, tag_addr, tag_load, tag_signed, tag_half, tag_byte, pop,
        output head_valid, head_addr, head_load, head_signed, head_half, head_byte
    );

    modport resp (
        output pop, fault_seen,
        input  head_valid, head_addr, head_load, head_signed, head_half, head_byte,
        input  misalign_ack
    );

endinterface

/* src/lsu_top.sv */
// Load/store unit top level
// Issuer, response tag FIFO and response formatter on one tag bundle
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Core side
    input  logic                    opcode_valid_i,
    input  logic [`LSU_XLEN-1:0]    opcode_i,
    input  logic [`LSU_XLEN-1:0]    ra_operand_i,
    input  logic [`LSU_XLEN-1:0]    rb_operand_i,
    output logic                    stall_o,

    // Memory request
    output logic [`LSU_XLEN-1:0]    mem_addr_o,
    output logic [`LSU_XLEN-1:0]    mem_data_wr_o,
    output logic                    mem_rd_o,
    output logic [`LSU_STRB_W-1:0]  mem_wr_o,

    // Memory response
    input  logic                    mem_accept_i,
    input  logic                    mem_ack_i,
    input  logic                    mem_error_i,
    input  logic [`LSU_XLEN-1:0]    mem_data_rd_i,

    // Writeback
    output logic                    writeback_valid_o,
    output logic [`LSU_XLEN-1:0]    writeback_value_o,
    output logic [`LSU_EXC_W-1:0]   writeback_exception_o
);

    lsu_tag_if u_tag_if ();

    lsu_issue u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .opcode_valid_i (opcode_valid_i),
        .opcode_i       (opcode_i),
        .ra_operand_i   (ra_operand_i),
        .rb_operand_i   (rb_operand_i),
        .mem_accept_i   (mem_accept_i),
        .mem_ack_i      (mem_ack_i),
        .mem_addr_o     (mem_addr_o),
        .mem_data_wr_o  (mem_data_wr_o),
        .mem_rd_o       (mem_rd_o),
        .mem_wr_o       (mem_wr_o),
        .stall_o        (stall_o),
        .tag            (u_tag_if.issue)
    );

    lsu_tag_fifo u_tag_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .tag   (u_tag_if.fifo)
    );

    lsu_response u_response (
        .mem_ack_i             (mem_ack_i),
        .mem_error_i           (mem_error_i),
        .mem_data_rd_i         (mem_data_rd_i),
        .writeback_valid_o     (writeback_valid_o),
        .writeback_value_o     (writeback_value_o),
        .writeback_exception_o (writeback_exception_o),
        .tag                   (u_tag_if.resp)
    );

endmodule
